// ==== dv/mem_unit_cases.txt ====
# op addr(word, hex) byteen(hex) wdata(hex) expected(hex)
# I ifetch, D/W global read/write, S/T shared read/write, P ifetch and data read together
D 00000010 0 00000000 5a5a5a4a
W 00000010 3 11223344 00000000
D 00000010 0 00000000 5a5a3344
W 00000010 c aabbccdd 00000000
D 00000010 0 00000000 aabb3344
W 00000020 f deadbeef 00000000
D 00000020 0 00000000 deadbeef
W 00000031 5 01020304 00000000
D 00000031 0 00000000 5a025a04
D 3fffffff 0 00000000 65a5a5a5
D 12345678 0 00000000 486e0c22
I 00000010 0 00000000 aabb3344
I 00000400 0 00000000 5a5a5e5a
I 00000abc 0 00000000 5a5a50e6
I 00000020 0 00000000 deadbeef
T 00000005 f cafef00d 00000000
S 00000005 0 00000000 cafef00d
T 00000005 2 00009900 00000000
S 00000005 0 00000000 cafe990d
T 00000105 8 77000000 00000000
S 00000005 0 00000000 77fe990d
T 000000ff f 0badf00d 00000000
S 000000ff 0 00000000 0badf00d
S 000001ff 0 00000000 0badf00d
S 00000105 0 00000000 77fe990d
D 00000005 0 00000000 5a5a5a5f
P 00000010 0 00000000 aabb3344
P 00000200 0 00000000 5a5a585a
P 00000031 0 00000000 5a025a04
P 00000777 0 00000000 5a5a5d2d
P 00001000 0 00000000 5a5a4a5a
P 00000020 0 00000000 deadbeef
W 00000777 9 a1b2c3d4 00000000
P 00000777 0 00000000 a15a5dd4
P 2aaaaaaa 0 00000000 70f0f0f0
I 00000031 0 00000000 5a025a04
D 00000abc 0 00000000 5a5a50e6

// ==== dv/mem_unit_tb.sv ====
module mem_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       icache_req_valid;
    mem_types_pkg::icache_req_t icache_req;
    logic                       icache_req_ready;
    logic                       icache_rsp_valid;
    mem_types_pkg::icache_rsp_t icache_rsp;
    logic                       icache_rsp_ready;
    logic                       dcache_req_valid;
    mem_types_pkg::dcache_req_t dcache_req;
    logic                       dcache_req_ready;
    logic                       dcache_rsp_valid;
    mem_types_pkg::dcache_rsp_t dcache_rsp;
    logic                       dcache_rsp_ready;
    logic                       mem_req_valid;
    mem_types_pkg::mem_req_t    mem_req;
    logic                       mem_req_ready;
    logic                       mem_rsp_valid;
    mem_types_pkg::mem_rsp_t    mem_rsp;
    logic                       mem_rsp_ready;
    perf_pkg::perf_memsys_t     perf;

    // External memory model state
    mem_types_pkg::data_t       ext_mem [mem_types_pkg::addr_t];
    mem_types_pkg::mem_rsp_t    pending [$];
    logic                       shared_tag [128];
    logic [31:0]                lfsr = 32'hf9d0284c;
    mem_types_pkg::core_tag_t   next_tag = '0;

    // Expected counter values seen at the memory port
    perf_pkg::perf_ctr_t        n_reads = '0;
    perf_pkg::perf_ctr_t        n_writes = '0;
    perf_pkg::perf_ctr_t        n_stalls = '0;
    perf_pkg::perf_ctr_t        n_latency = '0;
    perf_pkg::perf_ctr_t        n_outstanding = '0;

    mem_unit dut0 (.*);

    always #10 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else stop_with_error(
            $sformatf("FAILED %0.1f ns: %s is %0h, expected %0h",
                      $realtime, what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // Unwritten words read back as address XOR pattern
    function automatic mem_types_pkg::data_t unwritten_word(input mem_types_pkg::addr_t a);
        return {2'b00, a} ^ 32'h5a5a5a5a;
    endfunction

    initial begin
        logic                    req_fire;
        logic                    rsp_fire;
        logic                    launch;
        int                      idx;
        mem_types_pkg::mem_req_t req_seen;
        mem_types_pkg::data_t    word;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        icache_rsp_ready = 1'b0;
        dcache_rsp_ready = 1'b0;
        forever begin
            // Inputs are steady between the falling edge and the next rising edge
            @(negedge clk);
            req_fire = !reset && mem_req_valid && mem_req_ready;
            rsp_fire = !reset && mem_rsp_valid && mem_rsp_ready;
            req_seen = mem_req;
            if (!reset) begin
                n_latency += n_outstanding;
                if (mem_req_valid && !mem_req_ready) begin
                    n_stalls++;
                end
            end
            if (rsp_fire) begin
                n_outstanding--;
            end
            if (req_fire) begin
                if (req_seen.tag[0]) begin
                    assert (!shared_tag[req_seen.tag[mem_types_pkg::CORE_TAG_WIDTH:1]])
                        else stop_with_error("shared-memory request reached the memory port");
                end else begin
                    assert (!req_seen.rw && req_seen.byteen == '0)
                        else stop_with_error("instruction fetch on memory port is not a read");
                end
                word = ext_mem.exists(req_seen.addr) ? ext_mem[req_seen.addr]
                                                     : unwritten_word(req_seen.addr);
                if (req_seen.rw) begin
                    for (int i = 0; i < mem_types_pkg::WORD_BYTES; i++) begin
                        if (req_seen.byteen[i]) begin
                            word[i*8 +: 8] = req_seen.data[i*8 +: 8];
                        end
                    end
                    ext_mem[req_seen.addr] = word;
                    n_writes++;
                end else begin
                    pending.push_back('{word, req_seen.tag});
                    n_reads++;
                    n_outstanding++;
                end
            end
            @(posedge clk);
            #2;
            if (rsp_fire) begin
                mem_rsp_valid = 1'b0;
            end
            take_bit(launch);
            // With two reads waiting the younger one goes first
            if (!mem_rsp_valid && pending.size() > 0 && launch) begin
                idx = (pending.size() > 1) ? 1 : 0;
                mem_rsp = pending[idx];
                pending.delete(idx);
                mem_rsp_valid = 1'b1;
            end
            take_bit(mem_req_ready);
            take_bit(icache_rsp_ready);
            take_bit(dcache_rsp_ready);
        end
    end

    task automatic run_case(input logic [7:0] op, input mem_types_pkg::addr_t addr,
                            input mem_types_pkg::byteen_t byteen,
                            input mem_types_pkg::data_t wdata,
                            input mem_types_pkg::data_t expected);
        logic                     use_i;
        logic                     use_d;
        logic                     rw;
        logic                     smem;
        logic                     i_acc;
        logic                     d_acc;
        logic                     i_rsp_wait;
        logic                     d_rsp_wait;
        logic                     w_wait;
        mem_types_pkg::core_tag_t i_tag;
        mem_types_pkg::core_tag_t d_tag;
        perf_pkg::perf_ctr_t      writes_before;
        int                       cycles;
        if (!(op inside {"I", "D", "W", "S", "T", "P"})) begin
            stop_with_error($sformatf("unknown operation code %c in the cases file", op));
        end
        use_i = (op == "I" || op == "P");
        use_d = (op != "I");
        rw = (op == "W" || op == "T");
        smem = (op == "S" || op == "T");
        i_tag = next_tag;
        d_tag = next_tag + 1'b1;
        next_tag += 2;
        shared_tag[d_tag] = use_d && smem;
        icache_req.addr = addr;
        icache_req.tag = i_tag;
        icache_req_valid = use_i;
        dcache_req.rw = rw;
        dcache_req.byteen = byteen;
        dcache_req.addr = addr;
        dcache_req.data = wdata;
        dcache_req.tag = {d_tag, smem};
        dcache_req_valid = use_d;
        writes_before = n_writes;
        i_rsp_wait = use_i;
        d_rsp_wait = use_d && !rw;
        // Global writes finish when they show up at the memory port
        w_wait = use_d && rw && !smem;
        cycles = 0;
        while (icache_req_valid || dcache_req_valid || i_rsp_wait || d_rsp_wait || w_wait) begin
            if (cycles == 200) begin
                stop_with_error($sformatf("timeout in case %c %h: %s never arrived", op, addr,
                    i_rsp_wait ? "instruction response" :
                    d_rsp_wait ? "data response" :
                    w_wait ? "memory write" : "request acceptance"));
            end
            cycles++;
            @(negedge clk);
            i_acc = icache_req_valid && icache_req_ready;
            d_acc = dcache_req_valid && dcache_req_ready;
            if (icache_rsp_valid && icache_rsp_ready) begin
                assert (i_rsp_wait) else stop_with_error("unexpected instruction response");
                check_value("instruction data", icache_rsp.data, expected);
                check_value("instruction tag", icache_rsp.tag, i_tag);
                i_rsp_wait = 1'b0;
            end
            if (dcache_rsp_valid && dcache_rsp_ready) begin
                assert (d_rsp_wait) else stop_with_error("unexpected data response");
                check_value("data read", dcache_rsp.data, expected);
                check_value("data tag", dcache_rsp.tag, {d_tag, smem});
                d_rsp_wait = 1'b0;
            end
            @(posedge clk);
            #2;
            if (i_acc) begin
                icache_req_valid = 1'b0;
            end
            if (d_acc) begin
                dcache_req_valid = 1'b0;
            end
            if (n_writes != writes_before) begin
                w_wait = 1'b0;
            end
        end
    endtask

    initial begin
        int                      fd;
        int                      n;
        string                   line;
        logic [7:0]              op;
        mem_types_pkg::addr_t    addr;
        mem_types_pkg::byteen_t  byteen;
        mem_types_pkg::data_t    wdata;
        mem_types_pkg::data_t    expected;
        reset = 1'b1;
        icache_req_valid = 1'b0;
        icache_req = '0;
        dcache_req_valid = 1'b0;
        dcache_req = '0;
        foreach (shared_tag[i]) begin
            shared_tag[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        fd = $fopen("dv/mem_unit_cases.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open dv/mem_unit_cases.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h", op, addr, byteen, wdata, expected);
                if (n == 5) begin
                    run_case(op, addr, byteen, wdata, expected);
                end
            end
        end
        $fclose(fd);
        assert (pending.size() == 0) else stop_with_error("memory reads left unanswered");
        check_value("perf mem_reads", perf.mem_reads, n_reads);
        check_value("perf mem_writes", perf.mem_writes, n_writes);
        check_value("perf mem_stalls", perf.mem_stalls, n_stalls);
        check_value("perf mem_latency", perf.mem_latency, n_latency);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog/mem_arb.sv ====
module mem_arb (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       i_req_valid,
    input  mem_types_pkg::icache_req_t i_req,
    output logic                       i_req_ready,

    output logic                       i_rsp_valid,
    output mem_types_pkg::icache_rsp_t i_rsp,
    input  logic                       i_rsp_ready,

    input  logic                       d_req_valid,
    input  mem_types_pkg::core_req_t   d_req,
    output logic                       d_req_ready,

    output logic                       d_rsp_valid,
    output mem_types_pkg::core_rsp_t   d_rsp,
    input  logic                       d_rsp_ready,

    output logic                       mem_req_valid,
    output mem_types_pkg::mem_req_t    mem_req,
    input  logic                       mem_req_ready,

    input  logic                       mem_rsp_valid,
    input  mem_types_pkg::mem_rsp_t    mem_rsp,
    output logic                       mem_rsp_ready
);

    logic                    prio_data;
    logic                    grant_data;
    logic                    arb_valid;
    mem_types_pkg::mem_req_t arb_req;
    logic                    arb_ready;

    logic                    rbuf_valid;
    mem_types_pkg::mem_rsp_t rbuf;
    logic                    rbuf_ready;
    logic                    rsp_is_data;

    assign grant_data  = d_req_valid && (!i_req_valid || prio_data);
    assign arb_valid   = i_req_valid || d_req_valid;
    assign i_req_ready = arb_ready && !grant_data;
    assign d_req_ready = arb_ready && grant_data;

    // Instruction fetches go out as plain reads
    assign arb_req = grant_data ?
        '{d_req.rw, d_req.byteen, d_req.addr, d_req.data, {d_req.tag, 1'b1}} :
        '{1'b0, '0, i_req.addr, '0, {i_req.tag, 1'b0}};

    // Hold the grant through a stall, pass priority on after a transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            prio_data <= 1'b0;
        end else if (arb_valid) begin
            prio_data <= arb_ready ? !grant_data : grant_data;
        end
    end

    skid_buffer #(
        .payload_t (mem_types_pkg::mem_req_t)
    ) req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (arb_valid),
        .data_in   (arb_req),
        .ready_in  (arb_ready),
        .valid_out (mem_req_valid),
        .data_out  (mem_req),
        .ready_out (mem_req_ready)
    );

    skid_buffer #(
        .payload_t (mem_types_pkg::mem_rsp_t)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .data_in   (mem_rsp),
        .ready_in  (mem_rsp_ready),
        .valid_out (rbuf_valid),
        .data_out  (rbuf),
        .ready_out (rbuf_ready)
    );

    assign rsp_is_data = rbuf.tag[0];
    assign i_rsp_valid = rbuf_valid && !rsp_is_data;
    assign d_rsp_valid = rbuf_valid && rsp_is_data;
    assign rbuf_ready  = rsp_is_data ? d_rsp_ready : i_rsp_ready;

    assign i_rsp.data  = rbuf.data;
    assign i_rsp.tag   = rbuf.tag[mem_types_pkg::CORE_TAG_WIDTH:1];
    assign d_rsp.data  = rbuf.data;
    assign d_rsp.tag   = rbuf.tag[mem_types_pkg::CORE_TAG_WIDTH:1];

endmodule

// ==== verilog/mem_types_pkg.sv ====
package mem_types_pkg;

    localparam int ADDR_WIDTH       = 30;
    localparam int WORD_BYTES       = 4;
    localparam int DATA_WIDTH       = 32;
    localparam int CORE_TAG_WIDTH   = 7;
    localparam int SMEM_WORDS       = 256;
    localparam int SMEM_INDEX_WIDTH = 8;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [WORD_BYTES-1:0]     byteen_t;
    typedef logic [CORE_TAG_WIDTH-1:0] core_tag_t;

    // Bit 0 flags a shared-memory access
    typedef logic [CORE_TAG_WIDTH:0]   dcache_tag_t;

    // Bit 0 names the source, 0 for instruction and 1 for data
    typedef logic [CORE_TAG_WIDTH:0]   mem_tag_t;

    typedef struct packed {
        addr_t     addr;
        core_tag_t tag;
    } icache_req_t;

    typedef struct packed {
        data_t     data;
        core_tag_t tag;
    } icache_rsp_t;

    typedef struct packed {
        logic        rw;
        byteen_t     byteen;
        addr_t       addr;
        data_t       data;
        dcache_tag_t tag;
    } dcache_req_t;

    typedef struct packed {
        data_t       data;
        dcache_tag_t tag;
    } dcache_rsp_t;

    // Data request after the shared-memory flag is stripped
    typedef struct packed {
        logic      rw;
        byteen_t   byteen;
        addr_t     addr;
        data_t     data;
        core_tag_t tag;
    } core_req_t;

    typedef struct packed {
        data_t     data;
        core_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic     rw;
        byteen_t  byteen;
        addr_t    addr;
        data_t    data;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

endpackage

// ==== verilog/mem_unit.sv ====
module mem_unit (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       icache_req_valid,
    input  mem_types_pkg::icache_req_t icache_req,
    output logic                       icache_req_ready,

    output logic                       icache_rsp_valid,
    output mem_types_pkg::icache_rsp_t icache_rsp,
    input  logic                       icache_rsp_ready,

    input  logic                       dcache_req_valid,
    input  mem_types_pkg::dcache_req_t dcache_req,
    output logic                       dcache_req_ready,

    output logic                       dcache_rsp_valid,
    output mem_types_pkg::dcache_rsp_t dcache_rsp,
    input  logic                       dcache_rsp_ready,

    output logic                       mem_req_valid,
    output mem_types_pkg::mem_req_t    mem_req,
    input  logic                       mem_req_ready,

    input  logic                       mem_rsp_valid,
    input  mem_types_pkg::mem_rsp_t    mem_rsp,
    output logic                       mem_rsp_ready,

    output perf_pkg::perf_memsys_t     perf
);

    logic                     smem_req_valid;
    mem_types_pkg::core_req_t smem_req;
    logic                     smem_req_ready;
    logic                     smem_rsp_valid;
    mem_types_pkg::core_rsp_t smem_rsp;
    logic                     smem_rsp_ready;

    logic                     gmem_req_valid;
    mem_types_pkg::core_req_t gmem_req;
    logic                     gmem_req_ready;
    logic                     gmem_rsp_valid;
    mem_types_pkg::core_rsp_t gmem_rsp;
    logic                     gmem_rsp_ready;

    smem_arb smem_arb0 (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (dcache_req_valid),
        .req            (dcache_req),
        .req_ready      (dcache_req_ready),
        .rsp_valid      (dcache_rsp_valid),
        .rsp            (dcache_rsp),
        .rsp_ready      (dcache_rsp_ready),
        .smem_req_valid (smem_req_valid),
        .smem_req       (smem_req),
        .smem_req_ready (smem_req_ready),
        .smem_rsp_valid (smem_rsp_valid),
        .smem_rsp       (smem_rsp),
        .smem_rsp_ready (smem_rsp_ready),
        .gmem_req_valid (gmem_req_valid),
        .gmem_req       (gmem_req),
        .gmem_req_ready (gmem_req_ready),
        .gmem_rsp_valid (gmem_rsp_valid),
        .gmem_rsp       (gmem_rsp),
        .gmem_rsp_ready (gmem_rsp_ready)
    );

    shared_mem smem0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (smem_req_valid),
        .req       (smem_req),
        .req_ready (smem_req_ready),
        .rsp_valid (smem_rsp_valid),
        .rsp       (smem_rsp),
        .rsp_ready (smem_rsp_ready)
    );

    // Instruction fetch and global data share the memory port
    mem_arb mem_arb0 (
        .clk           (clk),
        .reset         (reset),
        .i_req_valid   (icache_req_valid),
        .i_req         (icache_req),
        .i_req_ready   (icache_req_ready),
        .i_rsp_valid   (icache_rsp_valid),
        .i_rsp         (icache_rsp),
        .i_rsp_ready   (icache_rsp_ready),
        .d_req_valid   (gmem_req_valid),
        .d_req         (gmem_req),
        .d_req_ready   (gmem_req_ready),
        .d_rsp_valid   (gmem_rsp_valid),
        .d_rsp         (gmem_rsp),
        .d_rsp_ready   (gmem_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    perf_counters perf0 (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req_rw    (mem_req.rw),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .perf          (perf)
    );

endmodule

// ==== verilog/perf_counters.sv ====
module perf_counters (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   mem_req_valid,
    input  logic                   mem_req_ready,
    input  logic                   mem_req_rw,
    input  logic                   mem_rsp_valid,
    input  logic                   mem_rsp_ready,

    output perf_pkg::perf_memsys_t perf
);

    perf_pkg::perf_ctr_t outstanding;

    logic req_fire;
    logic rd_fire;
    logic wr_fire;
    logic rsp_fire;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign rd_fire  = req_fire && !mem_req_rw;
    assign wr_fire  = req_fire && mem_req_rw;
    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    // Reads in flight on the memory port
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + perf_pkg::perf_ctr_t'(rd_fire)
                                       - perf_pkg::perf_ctr_t'(rsp_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            if (rd_fire) begin
                perf.mem_reads <= perf.mem_reads + 1'b1;
            end
            if (wr_fire) begin
                perf.mem_writes <= perf.mem_writes + 1'b1;
            end
            if (mem_req_valid && !mem_req_ready) begin
                perf.mem_stalls <= perf.mem_stalls + 1'b1;
            end
            // Total read latency in cycles
            perf.mem_latency <= perf.mem_latency + outstanding;
        end
    end

endmodule

// ==== verilog/perf_pkg.sv ====
package perf_pkg;

    localparam int PERF_CTR_WIDTH = 44;

    typedef logic [PERF_CTR_WIDTH-1:0] perf_ctr_t;

    // Memory port counters
    typedef struct packed {
        perf_ctr_t mem_reads;
        perf_ctr_t mem_writes;
        perf_ctr_t mem_stalls;
        perf_ctr_t mem_latency;
    } perf_memsys_t;

endpackage

// ==== verilog/shared_mem.sv ====
module shared_mem (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     req_valid,
    input  mem_types_pkg::core_req_t req,
    output logic                     req_ready,

    output logic                     rsp_valid,
    output mem_types_pkg::core_rsp_t rsp,
    input  logic                     rsp_ready
);

    mem_types_pkg::data_t mem [mem_types_pkg::SMEM_WORDS];

    logic [mem_types_pkg::SMEM_INDEX_WIDTH-1:0] index;
    logic                                       req_fire;
    logic                                       rd_fire;
    logic                                       wr_fire;

    assign index = req.addr[mem_types_pkg::SMEM_INDEX_WIDTH-1:0];

    // Stall requests while a read response waits for the core
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign rd_fire   = req_fire && !req.rw;
    assign wr_fire   = req_fire && req.rw;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp.data <= mem[index];
            rsp.tag  <= req.tag;
        end
    end

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < mem_types_pkg::WORD_BYTES; i++) begin
                if (req.byteen[i]) begin
                    mem[index][i*8 +: 8] <= req.data[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== verilog/skid_buffer.sv ====
module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     valid_in,
    input  payload_t data_in,
    output logic     ready_in,

    output logic     valid_out,
    output payload_t data_out,
    input  logic     ready_out
);

    payload_t skid_data;
    logic     skid_full;

    logic     push;
    logic     load_main;

    // Ready depends only on the skid entry, so it comes straight from a flop
    assign ready_in  = !skid_full;
    assign push      = valid_in && ready_in;
    assign load_main = !valid_out || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
            skid_full <= 1'b0;
        end else if (load_main) begin
            valid_out <= skid_full || valid_in;
            skid_full <= 1'b0;
        end else if (push) begin
            skid_full <= 1'b1;
        end
    end

    // Skid entry drains into the main register before new input
    always_ff @(posedge clk) begin
        if (load_main) begin
            data_out <= skid_full ? skid_data : data_in;
        end else if (push) begin
            skid_data <= data_in;
        end
    end

endmodule

// ==== verilog/smem_arb.sv ====
module smem_arb (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      req_valid,
    input  mem_types_pkg::dcache_req_t req,
    output logic                      req_ready,

    output logic                      rsp_valid,
    output mem_types_pkg::dcache_rsp_t rsp,
    input  logic                      rsp_ready,

    output logic                      smem_req_valid,
    output mem_types_pkg::core_req_t  smem_req,
    input  logic                      smem_req_ready,

    input  logic                      smem_rsp_valid,
    input  mem_types_pkg::core_rsp_t  smem_rsp,
    output logic                      smem_rsp_ready,

    output logic                      gmem_req_valid,
    output mem_types_pkg::core_req_t  gmem_req,
    input  logic                      gmem_req_ready,

    input  logic                      gmem_rsp_valid,
    input  mem_types_pkg::core_rsp_t  gmem_rsp,
    output logic                      gmem_rsp_ready
);

    logic                       buf_valid;
    mem_types_pkg::dcache_req_t buf_req;
    logic                       buf_ready;
    logic                       is_smem;

    skid_buffer #(
        .payload_t (mem_types_pkg::dcache_req_t)
    ) req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid),
        .data_in   (req),
        .ready_in  (req_ready),
        .valid_out (buf_valid),
        .data_out  (buf_req),
        .ready_out (buf_ready)
    );

    assign is_smem = buf_req.tag[0];

    assign smem_req_valid = buf_valid && is_smem;
    assign gmem_req_valid = buf_valid && !is_smem;
    assign buf_ready      = is_smem ? smem_req_ready : gmem_req_ready;

    assign smem_req = '{buf_req.rw, buf_req.byteen, buf_req.addr, buf_req.data,
                        buf_req.tag[mem_types_pkg::CORE_TAG_WIDTH:1]};
    assign gmem_req = smem_req;

    // Shared memory wins the response port
    assign rsp_valid      = smem_rsp_valid || gmem_rsp_valid;
    assign rsp.data       = smem_rsp_valid ? smem_rsp.data : gmem_rsp.data;
    assign rsp.tag        = smem_rsp_valid ? {smem_rsp.tag, 1'b1} : {gmem_rsp.tag, 1'b0};
    assign smem_rsp_ready = rsp_ready;
    assign gmem_rsp_ready = rsp_ready && !smem_rsp_valid;

endmodule

// ==== vlog.f ====
verilog/mem_types_pkg.sv
verilog/perf_pkg.sv
verilog/skid_buffer.sv
verilog/smem_arb.sv
verilog/shared_mem.sv
verilog/mem_arb.sv
verilog/perf_counters.sv
verilog/mem_unit.sv
dv/mem_unit_tb.sv
